//--- files.f
verilog/trellisPkg.sv
verilog/trellisRegs.sv
verilog/mfRotator.sv
verilog/phaseErrorScaler.sv
verilog/dacMonitorMux.sv
verilog/trellisFrontEnd.sv
testbench/trellisFrontEnd_assert.sv
testbench/trellisFrontEndTb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the trellis front end testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module trellisFrontEndTb -o simv
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
   exit 0
fi
echo "pass line missing from sim.log"
exit 1

//--- testbench/trellisFrontEndTb.sv
/*
   Testbench for the trellis front end.
   LFSR stimulus table applied once per symbol, Wishbone register
   access, rotation, phase-error and DAC checks, watchdog.
*/

`timescale 1ns/1ps
`default_nettype none

module trellisFrontEndTb;

   localparam int rotBits  = 10;
   localparam int sw       = trellisPkg::sampleWidth;
   localparam int numRows  = 24;
   localparam int numBus   = 3;
   localparam int wdClocks = numRows * 4 + numBus * 4 + 50;

   logic clk;
   logic arstN;
   logic symEn;
   logic [sw-1:0] iIn, qIn, mfmI, mfmQ, mfpI, mfpQ;
   logic [trellisPkg::phaseErrWidth-1:0] phaseError;
   logic [trellisPkg::indexWidth-1:0] index;
   logic wbCyc, wbStb, wbWe, wbAck;
   logic [trellisPkg::wbAdrWidth-1:0] wbAdr;
   logic [trellisPkg::wbDataWidth-1:0] wbDatW, wbDatR;
   logic [trellisPkg::decayWidth-1:0] decayFactor;
   logic [trellisPkg::phaseCtrlWidth-1:0] phaseCtrl;
   logic [3:0][rotBits-1:0] rotZReal, rotZImag, rotMReal, rotMImag, rotPReal, rotPImag;
   trellisPkg::dacSel_t dac0Select, dac1Select, dac2Select;
   logic [sw-1:0] dac0Data, dac1Data, dac2Data;
   logic dac0Sync, dac1Sync, dac2Sync;

   // sample columns: iIn, qIn, mfmI, mfmQ, mfpI, mfpQ
   logic [sw-1:0] tabSmp [numRows][6];
   logic [trellisPkg::phaseErrWidth-1:0] tabPe [numRows];
   logic [trellisPkg::indexWidth-1:0] tabIdx [numRows];
   trellisPkg::dacSel_t tabSel [numRows][3];
   logic [trellisPkg::phaseCtrlWidth-1:0] tabCtrl [numRows];
   logic [15:0] lfsrState;
   int errCount;

   trellisFrontEnd #(.rotBits(rotBits)) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------
   // reference model
   // ------------------------------

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic takeBits(input int n, output logic [sw-1:0] w);
      w = '0;
      for (int b = 0; b < n; b++) begin
         lfsrState = lfsrNext(lfsrState);
         w = {w[sw-2:0], lfsrState[0]};
      end
   endtask

   // doubled phase error, clamped when the top four bits disagree with the sign
   function automatic logic [7:0] satRule(input logic [9:0] pe);
      if (pe[9:6] == {4{pe[9]}}) begin
         return {pe[6:0], 1'b0};
      end else begin
         return pe[9] ? 8'h81 : 8'h7F;
      end
   endfunction

   function automatic logic [sw-1:0] dacRule(input trellisPkg::dacSel_t sel, input int n,
                                             input logic [7:0] ctrl);
      case (sel)
         trellisPkg::dacSelI:     return tabSmp[n][0];
         trellisPkg::dacSelQ:     return tabSmp[n][1];
         trellisPkg::dacSelIndex: return {1'b0, tabIdx[n], 12'h000};
         default:                 return {ctrl, 10'h000};
      endcase
   endfunction

   // real or imaginary parts of all four quarter turns, rot270 on top
   function automatic logic [4*rotBits-1:0] turnAll(input logic [rotBits-1:0] re,
                                                    input logic [rotBits-1:0] im,
                                                    input logic wantReal);
      logic [rotBits-1:0] negRe;
      logic [rotBits-1:0] negIm;
      negRe = -re;
      negIm = -im;
      if (wantReal) begin
         return {negIm, negRe, im, re};
      end else begin
         return {re, negIm, negRe, im};
      end
   endfunction

   // ------------------------------
   // checks and stimulus tasks
   // ------------------------------

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         errCount++;
         abortRun($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, want));
      end
   endtask

   task automatic pickRow(input int r, input logic [9:0] pe, input logic [7:0] ctrl);
      tabPe[r] = pe;
      tabCtrl[r] = ctrl;
   endtask

   task automatic fillTable();
      logic [sw-1:0] w;
      for (int r = 0; r < numRows; r++) begin
         for (int k = 0; k < 6; k++) begin
            takeBits(sw, w);
            tabSmp[r][k] = w;
         end
         takeBits(trellisPkg::phaseErrWidth, w);
         tabPe[r] = w[9:0];
         takeBits(trellisPkg::indexWidth, w);
         tabIdx[r] = w[4:0];
         tabSel[r][0] = trellisPkg::dacSel_t'(4'(r % 4));
         tabSel[r][1] = trellisPkg::dacSel_t'(4'((r + 1) % 4));
         // undefined code on channel 2 every third row
         tabSel[r][2] = trellisPkg::dacSel_t'((r % 3 == 0) ? 4'hB : 4'((r + 2) % 4));
         tabCtrl[r] = satRule(tabPe[r]);
      end
      // saturation at both signs, most negative value, plain shifts
      pickRow(0, 10'h07F, 8'h7F);
      pickRow(1, 10'h380, 8'h81);
      pickRow(2, 10'h200, 8'h81);
      pickRow(3, 10'h03F, 8'h7E);
      pickRow(4, 10'h3C1, 8'h82);
      for (int k = 0; k < 6; k++) begin
         tabSmp[2][k] = 18'h20000;
      end
   endtask

   // one Wishbone classic access, started 2 ns after a rising edge
   task automatic busAccess(input logic we, input logic [11:0] adr, input logic [31:0] dat,
                            output logic [31:0] rd);
      wbCyc = 1'b1;
      wbStb = 1'b1;
      wbWe = we;
      wbAdr = adr;
      wbDatW = dat;
      do begin
         @(posedge clk);
         #1;
      end while (!wbAck);
      rd = wbDatR;
      #1;
      {wbCyc, wbStb, wbWe} = 3'b000;
      @(posedge clk);
      #1;
      checkValue("wbAck", 64'(wbAck), 64'h0);
      #1;
   endtask

   // outputs one clock after the enable of row n
   task automatic checkSymbol(input int n);
      logic [rotBits-1:0] zRe;
      logic [rotBits-1:0] zIm;
      logic [rotBits-1:0] mRe;
      logic [rotBits-1:0] mIm;
      logic [rotBits-1:0] pRe;
      logic [rotBits-1:0] pIm;
      logic [7:0] ctrlNow;
      logic [7:0] ctrlDac;
      int z;
      z = n - trellisPkg::mfzDelay;
      zRe = '0;
      zIm = '0;
      // zero stream lags five enables and is halved
      if (z >= 0) begin
         zRe = {tabSmp[z][0][sw-1], tabSmp[z][0][sw-1 -: rotBits-1]};
         zIm = {tabSmp[z][1][sw-1], tabSmp[z][1][sw-1 -: rotBits-1]};
      end
      mRe = tabSmp[n][2][sw-1 -: rotBits];
      mIm = tabSmp[n][3][sw-1 -: rotBits];
      pRe = tabSmp[n][4][sw-1 -: rotBits];
      pIm = tabSmp[n][5][sw-1 -: rotBits];
      ctrlNow = 8'h00;
      ctrlDac = 8'h00;
      if (n >= 1) begin
         ctrlNow = tabCtrl[n-1];
      end
      // DAC register sampled phaseCtrl before this enable
      if (n >= 2) begin
         ctrlDac = tabCtrl[n-2];
      end
      checkValue("rotZReal", 64'(rotZReal), 64'(turnAll(zRe, zIm, 1'b1)));
      checkValue("rotZImag", 64'(rotZImag), 64'(turnAll(zRe, zIm, 1'b0)));
      checkValue("rotMReal", 64'(rotMReal), 64'(turnAll(mRe, mIm, 1'b1)));
      checkValue("rotMImag", 64'(rotMImag), 64'(turnAll(mRe, mIm, 1'b0)));
      checkValue("rotPReal", 64'(rotPReal), 64'(turnAll(pRe, pIm, 1'b1)));
      checkValue("rotPImag", 64'(rotPImag), 64'(turnAll(pRe, pIm, 1'b0)));
      checkValue("phaseCtrl", 64'(phaseCtrl), 64'(ctrlNow));
      checkValue("dac0Data", 64'(dac0Data), 64'(dacRule(tabSel[n][0], n, ctrlDac)));
      checkValue("dac1Data", 64'(dac1Data), 64'(dacRule(tabSel[n][1], n, ctrlDac)));
      checkValue("dac2Data", 64'(dac2Data), 64'(dacRule(tabSel[n][2], n, ctrlDac)));
      checkValue("dacSync", 64'({dac2Sync, dac1Sync, dac0Sync}), 64'h7);
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      logic [trellisPkg::wbDataWidth-1:0] rd;
      errCount = 0;
      lfsrState = 16'd47;
      arstN = 1'b0;
      symEn = 1'b0;
      {iIn, qIn, mfmI, mfmQ, mfpI, mfpQ} = '0;
      {wbCyc, wbStb, wbWe} = 3'b000;
      wbAdr = '0;
      wbDatW = '0;
      phaseError = '0;
      index = '0;
      dac0Select = trellisPkg::dacSelI;
      dac1Select = trellisPkg::dacSelI;
      dac2Select = trellisPkg::dacSelI;
      fillTable();
      repeat (10) @(posedge clk);
      #2 arstN = 1'b1;
      @(posedge clk);
      #1;
      checkValue("wbAck", 64'(wbAck), 64'h0);
      checkValue("decayFactor", 64'(decayFactor), 64'h0);
      checkValue("phaseCtrl", 64'(phaseCtrl), 64'h0);
      checkValue("rotations", 64'(rotZReal | rotZImag | rotMReal | rotMImag | rotPReal | rotPImag),
                 64'h0);
      checkValue("dacSync", 64'({dac2Sync, dac1Sync, dac0Sync}), 64'h0);
      #1;
      // decay register, then an unmapped read
      busAccess(1'b1, trellisPkg::regDecayAddr, 32'hA5C3_5E96, rd);
      checkValue("decayFactor", 64'(decayFactor), 64'h96);
      busAccess(1'b0, trellisPkg::regDecayAddr, 32'h0, rd);
      checkValue("wbDatR", 64'(rd), 64'h96);
      busAccess(1'b0, 12'h044, 32'h0, rd);
      checkValue("wbDatR", 64'(rd), 64'h0);
      // one row per symbol, enable every fourth clock
      for (int n = 0; n < numRows; n++) begin
         iIn = tabSmp[n][0];
         qIn = tabSmp[n][1];
         mfmI = tabSmp[n][2];
         mfmQ = tabSmp[n][3];
         mfpI = tabSmp[n][4];
         mfpQ = tabSmp[n][5];
         phaseError = tabPe[n];
         index = tabIdx[n];
         dac0Select = tabSel[n][0];
         dac1Select = tabSel[n][1];
         dac2Select = tabSel[n][2];
         symEn = 1'b1;
         @(posedge clk);
         #1;
         checkSymbol(n);
         #1 symEn = 1'b0;
         @(posedge clk);
         #1;
         checkValue("dacSync", 64'({dac2Sync, dac1Sync, dac0Sync}), 64'h0);
         repeat (2) @(posedge clk);
         #2;
      end
      // one more enable pushes out the last phase error
      symEn = 1'b1;
      @(posedge clk);
      #1;
      checkValue("phaseCtrl", 64'(phaseCtrl), 64'(tabCtrl[numRows-1]));
      #1 symEn = 1'b0;
      if (errCount == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         abortRun("checks recorded errors");
      end
   end

   initial begin
      repeat (wdClocks) @(posedge clk);
      abortRun("watchdog expired before the test sequence finished");
   end

endmodule

`default_nettype wire

//--- testbench/trellisFrontEnd_assert.sv
/*
   Concurrent assertions on the Wishbone acknowledge
   and the DAC sync strobes, bound into the DUT.
*/

`timescale 1ns/1ps
`default_nettype none

module trellisFrontEnd_assert (
   input wire logic       clk,
   input wire logic       arstN,
   input wire logic       wbCyc,
   input wire logic       wbStb,
   input wire logic       wbAck,
   input wire logic       symEn,
   input wire logic [2:0] dacSync
);

   // ack only answers a request
   ackAfterReq: assert property (@(posedge clk) disable iff (!arstN)
      wbAck |-> $past(wbCyc && wbStb))
      else $error("wbAck without a preceding request");

   ackSingle: assert property (@(posedge clk) disable iff (!arstN)
      wbAck |=> !wbAck)
      else $error("wbAck high for two clocks");

   // every sync is symEn one clock late
   syncFollowsEn: assert property (@(posedge clk) disable iff (!arstN)
      dacSync == {3{$past(symEn)}})
      else $error("DAC sync out of step with symEn");

endmodule

bind trellisRegs trellisFrontEnd_assert i_regsAssert (
   .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
   .symEn(1'b0), .dacSync(3'b000)
);

bind dacMonitorMux trellisFrontEnd_assert i_dacAssert (
   .clk(clk), .arstN(arstN), .wbCyc(1'b0), .wbStb(1'b0), .wbAck(1'b0),
   .symEn(symEn), .dacSync({dac2Sync, dac1Sync, dac0Sync})
);

`default_nettype wire

//--- verilog/trellisFrontEnd.sv
/*
   Symbol-rate front end of the SOQPSK trellis demodulator.
   Connects the decay register, the matched-filter rotation bank,
   the phase-error scaler and the monitor DAC mux.
*/

`timescale 1ns/1ps
`default_nettype none

module trellisFrontEnd #(
   parameter int rotBits = 10
) (
   input  wire logic                                   clk,
   input  wire logic                                   arstN,
   input  wire logic                                   symEn,
   // carrier-corrected sample, also the zero-filter stream
   input  wire logic [trellisPkg::sampleWidth-1:0]     iIn,
   input  wire logic [trellisPkg::sampleWidth-1:0]     qIn,
   input  wire logic [trellisPkg::sampleWidth-1:0]     mfmI,
   input  wire logic [trellisPkg::sampleWidth-1:0]     mfmQ,
   input  wire logic [trellisPkg::sampleWidth-1:0]     mfpI,
   input  wire logic [trellisPkg::sampleWidth-1:0]     mfpQ,
   // from the viterbi decoder
   input  wire logic [trellisPkg::phaseErrWidth-1:0]   phaseError,
   input  wire logic [trellisPkg::indexWidth-1:0]      index,
   // wishbone slave
   input  wire logic                                   wbCyc,
   input  wire logic                                   wbStb,
   input  wire logic                                   wbWe,
   input  wire logic [trellisPkg::wbAdrWidth-1:0]      wbAdr,
   input  wire logic [trellisPkg::wbDataWidth-1:0]     wbDatW,
   output logic      [trellisPkg::wbDataWidth-1:0]     wbDatR,
   output logic                                        wbAck,
   output logic      [trellisPkg::decayWidth-1:0]      decayFactor,
   // carrier loop steering
   output logic      [trellisPkg::phaseCtrlWidth-1:0]  phaseCtrl,
   // branch metric inputs, indexed by rotation
   output logic      [3:0][rotBits-1:0]                rotZReal,
   output logic      [3:0][rotBits-1:0]                rotZImag,
   output logic      [3:0][rotBits-1:0]                rotMReal,
   output logic      [3:0][rotBits-1:0]                rotMImag,
   output logic      [3:0][rotBits-1:0]                rotPReal,
   output logic      [3:0][rotBits-1:0]                rotPImag,
   // monitor DACs
   input  wire trellisPkg::dacSel_t                    dac0Select,
   input  wire trellisPkg::dacSel_t                    dac1Select,
   input  wire trellisPkg::dacSel_t                    dac2Select,
   output logic      [trellisPkg::sampleWidth-1:0]     dac0Data,
   output logic      [trellisPkg::sampleWidth-1:0]     dac1Data,
   output logic      [trellisPkg::sampleWidth-1:0]     dac2Data,
   output logic                                        dac0Sync,
   output logic                                        dac1Sync,
   output logic                                        dac2Sync
);

   trellisRegs i_regs (
      .clk         (clk),
      .arstN       (arstN),
      .wbCyc       (wbCyc),
      .wbStb       (wbStb),
      .wbWe        (wbWe),
      .wbAdr       (wbAdr),
      .wbDatW      (wbDatW),
      .wbDatR      (wbDatR),
      .wbAck       (wbAck),
      .decayFactor (decayFactor)
   );

   mfRotator #(
      .rotBits (rotBits)
   ) i_rotator (
      .clk      (clk),
      .arstN    (arstN),
      .symEn    (symEn),
      .iIn      (iIn),
      .qIn      (qIn),
      .mfmI     (mfmI),
      .mfmQ     (mfmQ),
      .mfpI     (mfpI),
      .mfpQ     (mfpQ),
      .rotZReal (rotZReal),
      .rotZImag (rotZImag),
      .rotMReal (rotMReal),
      .rotMImag (rotMImag),
      .rotPReal (rotPReal),
      .rotPImag (rotPImag)
   );

   phaseErrorScaler i_phErr (
      .clk        (clk),
      .arstN      (arstN),
      .symEn      (symEn),
      .phaseError (phaseError),
      .phaseCtrl  (phaseCtrl)
   );

   dacMonitorMux i_dacMux (
      .clk        (clk),
      .arstN      (arstN),
      .symEn      (symEn),
      .iIn        (iIn),
      .qIn        (qIn),
      .phaseCtrl  (phaseCtrl),
      .index      (index),
      .dac0Select (dac0Select),
      .dac1Select (dac1Select),
      .dac2Select (dac2Select),
      .dac0Data   (dac0Data),
      .dac1Data   (dac1Data),
      .dac2Data   (dac2Data),
      .dac0Sync   (dac0Sync),
      .dac1Sync   (dac1Sync),
      .dac2Sync   (dac2Sync)
   );

endmodule

`default_nettype wire

//--- verilog/dacMonitorMux.sv
/*
   Monitor DAC mux, three registered channels,
   each with its own source select and sync strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module dacMonitorMux (
   input  wire logic                                  clk,
   input  wire logic                                  arstN,
   input  wire logic                                  symEn,
   input  wire logic [trellisPkg::sampleWidth-1:0]    iIn,
   input  wire logic [trellisPkg::sampleWidth-1:0]    qIn,
   input  wire logic [trellisPkg::phaseCtrlWidth-1:0] phaseCtrl,
   input  wire logic [trellisPkg::indexWidth-1:0]     index,
   input  wire trellisPkg::dacSel_t                   dac0Select,
   input  wire trellisPkg::dacSel_t                   dac1Select,
   input  wire trellisPkg::dacSel_t                   dac2Select,
   output logic      [trellisPkg::sampleWidth-1:0]    dac0Data,
   output logic      [trellisPkg::sampleWidth-1:0]    dac1Data,
   output logic      [trellisPkg::sampleWidth-1:0]    dac2Data,
   output logic                                       dac0Sync,
   output logic                                       dac1Sync,
   output logic                                       dac2Sync
);

   localparam int sw = trellisPkg::sampleWidth;

   // source formatted to the DAC word, MSB aligned
   function automatic logic [sw-1:0] dacSource(input trellisPkg::dacSel_t sel);
      case (sel)
         trellisPkg::dacSelI:     dacSource = iIn;
         trellisPkg::dacSelQ:     dacSource = qIn;
         trellisPkg::dacSelIndex: dacSource = {1'b0, index, 12'b0};
         default:                 dacSource = {phaseCtrl, 10'b0};
      endcase
   endfunction

   // data words
   always_ff @(posedge clk) begin
      dac0Data <= dacSource(dac0Select);
      dac1Data <= dacSource(dac1Select);
      dac2Data <= dacSource(dac2Select);
   end

   // symbol-rate strobes, aligned with the data
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dac0Sync <= 1'b0;
         dac1Sync <= 1'b0;
         dac2Sync <= 1'b0;
      end else begin
         dac0Sync <= symEn;
         dac1Sync <= symEn;
         dac2Sync <= symEn;
      end
   end

endmodule

`default_nettype wire

//--- verilog/phaseErrorScaler.sv
/*
   Doubling of the decoder phase error with saturation,
   two enabled pipeline stages.
*/

`timescale 1ns/1ps
`default_nettype none

module phaseErrorScaler (
   input  wire logic                                  clk,
   input  wire logic                                  arstN,
   input  wire logic                                  symEn,
   input  wire logic [trellisPkg::phaseErrWidth-1:0]  phaseError,
   output logic      [trellisPkg::phaseCtrlWidth-1:0] phaseCtrl
);

   localparam int ew = trellisPkg::phaseErrWidth;
   localparam int cw = trellisPkg::phaseCtrlWidth;
   // bits that must all match the sign for the shift to fit
   localparam int headBits = ew - cw + 2;

   localparam logic [cw-1:0] maxPos = {1'b0, {(cw-1){1'b1}}};
   localparam logic [cw-1:0] maxNeg = {1'b1, {(cw-2){1'b0}}, 1'b1};

   logic [headBits-1:0] head;
   logic [cw-1:0]       dataBits;
   logic                satPos;
   logic                satNeg;

   assign head = phaseError[ew-1 -: headBits];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dataBits  <= '0;
         satPos    <= 1'b0;
         satNeg    <= 1'b0;
         phaseCtrl <= '0;
      end else if (symEn) begin
         // stage 1, shift and overflow flags
         dataBits <= {phaseError[cw-2:0], 1'b0};
         satPos   <= !head[headBits-1] && (|head);
         satNeg   <= head[headBits-1] && !(&head);
         // stage 2, clamp symmetric around zero
         if (satPos) begin
            phaseCtrl <= maxPos;
         end else if (satNeg) begin
            phaseCtrl <= maxNeg;
         end else begin
            phaseCtrl <= dataBits;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/mfRotator.sv
/*
   Matched-filter rotation bank.
   Zero stream alignment delay and halving, scaling of the
   minus and plus streams, four quarter-turn rotations of each.
*/

`timescale 1ns/1ps
`default_nettype none

module mfRotator #(
   parameter int rotBits = 10
) (
   input  wire logic                               clk,
   input  wire logic                               arstN,
   input  wire logic                               symEn,
   input  wire logic [trellisPkg::sampleWidth-1:0] iIn,
   input  wire logic [trellisPkg::sampleWidth-1:0] qIn,
   input  wire logic [trellisPkg::sampleWidth-1:0] mfmI,
   input  wire logic [trellisPkg::sampleWidth-1:0] mfmQ,
   input  wire logic [trellisPkg::sampleWidth-1:0] mfpI,
   input  wire logic [trellisPkg::sampleWidth-1:0] mfpQ,
   output logic      [3:0][rotBits-1:0]            rotZReal,
   output logic      [3:0][rotBits-1:0]            rotZImag,
   output logic      [3:0][rotBits-1:0]            rotMReal,
   output logic      [3:0][rotBits-1:0]            rotMImag,
   output logic      [3:0][rotBits-1:0]            rotPReal,
   output logic      [3:0][rotBits-1:0]            rotPImag
);

   localparam int sw    = trellisPkg::sampleWidth;
   localparam int depth = trellisPkg::mfzDelay;

   // alignment shift registers, newest sample at index 0
   logic [depth-1:0][sw-1:0] zDlyI;
   logic [depth-1:0][sw-1:0] zDlyQ;

   logic [sw-1:0]      mfzI;
   logic [sw-1:0]      mfzQ;
   logic [rotBits-1:0] zRe;
   logic [rotBits-1:0] zIm;
   logic [rotBits-1:0] mRe;
   logic [rotBits-1:0] mIm;
   logic [rotBits-1:0] pRe;
   logic [rotBits-1:0] pIm;

   // returns {real, imag} of (re, im) turned by rot
   function automatic logic [2*rotBits-1:0] rotate(
      input logic [rotBits-1:0]   re,
      input logic [rotBits-1:0]   im,
      input trellisPkg::rotation_t rot
   );
      case (rot)
         trellisPkg::rot0:   rotate = {re, im};
         trellisPkg::rot90:  rotate = {im, -re};
         trellisPkg::rot180: rotate = {-re, -im};
         default:            rotate = {-im, re};
      endcase
   endfunction

   // ------------------------------
   // zero stream alignment
   // ------------------------------

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         zDlyI <= '0;
         zDlyQ <= '0;
      end else if (symEn) begin
         zDlyI <= {zDlyI[depth-2:0], iIn};
         zDlyQ <= {zDlyQ[depth-2:0], qIn};
      end
   end

   assign mfzI = zDlyI[depth-1];
   assign mfzQ = zDlyQ[depth-1];

   // ------------------------------
   // scaling
   // ------------------------------

   // zero stream halved, the other two keep full scale
   assign zRe = {mfzI[sw-1], mfzI[sw-1 -: rotBits-1]};
   assign zIm = {mfzQ[sw-1], mfzQ[sw-1 -: rotBits-1]};

   assign mRe = mfmI[sw-1 -: rotBits];
   assign mIm = mfmQ[sw-1 -: rotBits];
   assign pRe = mfpI[sw-1 -: rotBits];
   assign pIm = mfpQ[sw-1 -: rotBits];

   // ------------------------------
   // rotation registers
   // ------------------------------

   // all 24 words update together on the symbol enable
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         rotZReal <= '0;
         rotZImag <= '0;
         rotMReal <= '0;
         rotMImag <= '0;
         rotPReal <= '0;
         rotPImag <= '0;
      end else if (symEn) begin
         for (int r = 0; r < 4; r++) begin
            {rotZReal[r], rotZImag[r]} <= rotate(zRe, zIm, trellisPkg::rotation_t'(r));
            {rotMReal[r], rotMImag[r]} <= rotate(mRe, mIm, trellisPkg::rotation_t'(r));
            {rotPReal[r], rotPImag[r]} <= rotate(pRe, pIm, trellisPkg::rotation_t'(r));
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/trellisRegs.sv
/*
   Wishbone classic slave for the trellis registers.
   Address decode, decay-factor register, single-clock ack.
*/

`timescale 1ns/1ps
`default_nettype none

module trellisRegs (
   input  wire logic                                clk,
   input  wire logic                                arstN,
   input  wire logic                                wbCyc,
   input  wire logic                                wbStb,
   input  wire logic                                wbWe,
   input  wire logic [trellisPkg::wbAdrWidth-1:0]   wbAdr,
   input  wire logic [trellisPkg::wbDataWidth-1:0]  wbDatW,
   output logic      [trellisPkg::wbDataWidth-1:0]  wbDatR,
   output logic                                     wbAck,
   output logic      [trellisPkg::decayWidth-1:0]   decayFactor
);

   logic busReq;
   logic decayHit;
   logic accept;

   // ------------------------------
   // bus handshake
   // ------------------------------

   assign busReq = wbCyc && wbStb;

   // one ack per cycle, never back to back
   assign accept = busReq && !wbAck;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wbAck <= 1'b0;
      end else begin
         wbAck <= accept;
      end
   end

   // ------------------------------
   // decode and registers
   // ------------------------------

   assign decayHit = (wbAdr == trellisPkg::regDecayAddr);

   // write lands on the clock that raises the ack
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decayFactor <= '0;
      end else if (accept && wbWe && decayHit) begin
         decayFactor <= wbDatW[trellisPkg::decayWidth-1:0];
      end
   end

   // address is held by the master until ack, so readback
   // straight from the decode is stable while ack is high
   always_comb begin
      wbDatR = '0;
      if (decayHit) begin
         wbDatR[trellisPkg::decayWidth-1:0] = decayFactor;
      end
   end

endmodule

`default_nettype wire

//--- verilog/trellisPkg.sv
/*
   Shared definitions for the trellis front end:
   sample and bus widths, register address map,
   DAC source select and quarter-turn rotation enums
*/

`default_nettype none

package trellisPkg;

   // ------------------------------
   // datapath widths
   // ------------------------------
   localparam int sampleWidth    = 18;
   localparam int phaseErrWidth  = 10;
   localparam int phaseCtrlWidth = 8;
   localparam int indexWidth     = 5;

   // zero stream alignment, in symbol enables
   localparam int mfzDelay = 5;

   // ------------------------------
   // wishbone and register map
   // ------------------------------
   localparam int wbAdrWidth  = 12;
   localparam int wbDataWidth = 32;
   localparam int decayWidth  = 8;

   // word addresses
   localparam logic [wbAdrWidth-1:0] regDecayAddr = 12'h040;

   // monitor DAC source, unknown codes fall back to phase error
   typedef enum logic [3:0] {
      dacSelI     = 4'd0,
      dacSelQ     = 4'd1,
      dacSelPhErr = 4'd2,
      dacSelIndex = 4'd3
   } dacSel_t;

   // quarter turns applied to a complex sample
   typedef enum logic [1:0] {
      rot0   = 2'd0,
      rot90  = 2'd1,
      rot180 = 2'd2,
      rot270 = 2'd3
   } rotation_t;

endpackage

`default_nettype wire
